/* hw/branchPkg.sv */
package branchPkg;

    // Datapath and table geometry
    localparam int dataWidth = 16;
    localparam int instrWidth = 16;
    localparam int hashWidth = 6;
    localparam int preservedBits = 3;
    localparam int foldBits = hashWidth - preservedBits;
    localparam int tableDepth = 1 << hashWidth;
    localparam int offsetWidth = 10;

    typedef logic [dataWidth-1:0] addrT;
    typedef logic [instrWidth-1:0] instrT;
    typedef logic [hashWidth-1:0] hashT;

    // Upper bit is the predicted direction
    typedef logic [1:0] counterT;

    typedef enum logic {
        idle,
        speculating
    } windowStateT;

    // Two-bit saturating counter step
    function automatic counterT nextCounter(input counterT count, input logic taken);
        counterT result;
        if (taken) begin
            result = (count == 2'd3) ? count : count + 2'd1;
        end else begin
            result = (count == 2'd0) ? count : count - 2'd1;
        end
        return result;
    endfunction

    // Keep the low address bits, XOR the rest down in foldBits groups
    function automatic hashT foldAddress(input addrT addr);
        logic [foldBits-1:0] folded;
        addrT rest;
        folded = '0;
        rest = addr >> preservedBits;
        for (int i = 0; i < dataWidth; i += foldBits) begin
            // Top group runs short and is zero-extended by the shift
            folded ^= rest[foldBits-1:0];
            rest = rest >> foldBits;
        end
        return {folded, addr[preservedBits-1:0]};
    endfunction

endpackage : branchPkg

/* hw/branchDecode.sv */
`timescale 1ns/100ps

module branchDecode
    import branchPkg::*;
(
    input  instrT fetchInstruction,
    input  addrT  fetchAddress,

    output logic  isBranch,
    output logic  isImmediate,
    output logic  isUnconditional,
    output logic  needsWindow,
    output addrT  destination
);

    logic immRegAZero;
    logic regRegAZero;
    logic regAZero;
    logic [offsetWidth-1:0] offset;
    addrT offsetExtended;
    addrT immDestination;

    // Branch opcode sits in the top two bits
    assign isBranch = (fetchInstruction[15:14] == 2'b10);

    // Bit 12 picks immediate form over register form
    assign isImmediate = isBranch && fetchInstruction[12];

    // Register A field is 2 bits wide in immediate form, 4 bits in register form
    assign immRegAZero = (fetchInstruction[11:10] == 2'b00);
    assign regRegAZero = (fetchInstruction[11:8] == 4'b0000);
    assign regAZero = fetchInstruction[12] ? immRegAZero : regRegAZero;

    // Register A zero means the branch is always taken, in either form
    assign isUnconditional = isBranch && regAZero;

    // Only the immediate unconditional case skips the window;
    // a register branch on A zero still has an unknown target
    assign needsWindow = isBranch && !(fetchInstruction[12] && immRegAZero);

    // Destination
    assign offset = fetchInstruction[offsetWidth-1:0];
    assign offsetExtended = {{(dataWidth-offsetWidth){offset[offsetWidth-1]}}, offset};
    assign immDestination = fetchAddress + offsetExtended;

    // Register targets come from the register file, outside this stage
    assign destination = isImmediate ? immDestination : '0;

endmodule : branchDecode

/* hw/predictorTables.sv */
`timescale 1ns/100ps

module predictorTables
    import branchPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic clkEn,

    input  addrT fetchAddress,

    output hashT lookupHash,
    output logic tableValid,
    output logic tablePrediction,
    output logic globalPrediction,

    input  logic trainEnable,
    input  logic trainTable,
    input  hashT trainHash,
    input  logic trainTaken
);

    // Entries stay invalid until their first training write
    logic [tableDepth-1:0] entryValid;
    counterT patternTable [tableDepth];
    counterT globalCounter;

    counterT lookupCounter;
    counterT trainCounter;
    logic trainEntryValid;
    counterT trainCounterNext;

    // Lookup path
    assign lookupHash = foldAddress(fetchAddress);
    assign lookupCounter = patternTable[lookupHash];
    assign tableValid = entryValid[lookupHash];
    assign tablePrediction = lookupCounter[1];
    assign globalPrediction = globalCounter[1];

    // Training path
    assign trainCounter = patternTable[trainHash];
    assign trainEntryValid = entryValid[trainHash];

    always_comb begin
        if (trainEntryValid) begin
            trainCounterNext = nextCounter(trainCounter, trainTaken);
        end else if (trainTaken) begin
            // First write lands on the weak side of the outcome
            trainCounterNext = 2'd2;
        end else begin
            trainCounterNext = 2'd1;
        end
    end

    // Global counter starts strongly not-taken out of reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            globalCounter <= 2'd0;
        end else if (clkEn && trainEnable) begin
            globalCounter <= nextCounter(globalCounter, trainTaken);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
        end else if (clkEn && trainEnable && trainTable) begin
            entryValid[trainHash] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && trainEnable && trainTable) begin
            patternTable[trainHash] <= trainCounterNext;
        end
    end

    // Table training is always a refinement of a global update
    trainTableNeedsEnable: assert property (
        @(posedge clk) disable iff (!rstN)
        trainTable |-> trainEnable
    ) else $error("trainTable raised without trainEnable");

endmodule : predictorTables

/* hw/speculationControl.sv */
`timescale 1ns/100ps

module speculationControl
    import branchPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic clkEn,

    input  logic isBranch,
    input  logic isImmediate,
    input  logic isUnconditional,
    input  logic needsWindow,

    input  hashT lookupHash,
    input  logic tableValid,
    input  logic tablePrediction,
    input  logic globalPrediction,

    input  logic endSpeculation,
    input  logic mispredicted,

    output logic speculating,
    output logic beginSpeculation,
    output logic speculationStall,
    output logic predictingTrue,

    output logic trainEnable,
    output logic trainTable,
    output logic trainTaken,
    output hashT trainHash
);

    windowStateT state;
    logic prediction;

    // State of the open window, captured at the begin pulse
    hashT savedHash;
    logic savedPrediction;
    logic savedImmediate;

    assign speculating = (state != idle);

    // A stall also covers the end-pulse cycle; the retry starts a cycle later
    assign beginSpeculation = needsWindow && !speculating;
    assign speculationStall = needsWindow && speculating;

    // Table entry only for conditional immediate branches
    always_comb begin
        if (isUnconditional) begin
            prediction = 1'b1;
        end else if (isImmediate && tableValid) begin
            prediction = tablePrediction;
        end else begin
            prediction = globalPrediction;
        end
    end

    assign predictingTrue = isBranch && prediction;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
        end else if (clkEn) begin
            case (state)
                idle: begin
                    if (beginSpeculation) begin
                        state <= branchPkg::speculating;
                    end
                end
                default: begin
                    if (endSpeculation) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && beginSpeculation) begin
            savedHash <= lookupHash;
            savedPrediction <= prediction;
            savedImmediate <= isImmediate;
        end
    end

    // Outcome is the stored guess, flipped on a mispredict
    assign trainEnable = endSpeculation && speculating;
    assign trainTable = trainEnable && savedImmediate;
    assign trainTaken = savedPrediction ^ mispredicted;
    assign trainHash = savedHash;

    endOnlyInWindow: assert property (
        @(posedge clk) disable iff (!rstN)
        endSpeculation |-> speculating
    ) else $error("endSpeculation outside a speculation window");

    mispredictWithEnd: assert property (
        @(posedge clk) disable iff (!rstN)
        mispredicted |-> endSpeculation
    ) else $error("mispredicted without endSpeculation");

endmodule : speculationControl

/* hw/branchExaminer.sv */
`timescale 1ns/100ps

module branchExaminer
    import branchPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  clkEn,

    input  addrT  fetchAddress,
    input  instrT fetchInstruction,

    input  logic  endSpeculation,
    input  logic  mispredicted,

    output logic  speculating,
    output logic  beginSpeculation,
    output logic  relativeSpeculation,
    output logic  predictingTrue,
    output addrT  speculativeDestination,
    output logic  speculationStall
);

    // Decode results
    logic isBranch;
    logic isImmediate;
    logic isUnconditional;
    logic needsWindow;

    // Predictor lookups
    hashT lookupHash;
    logic tableValid;
    logic tablePrediction;
    logic globalPrediction;

    // Training orders back from control
    logic trainEnable;
    logic trainTable;
    logic trainTaken;
    hashT trainHash;

    branchDecode decode_i (
        .fetchInstruction(fetchInstruction),
        .fetchAddress    (fetchAddress),
        .isBranch        (isBranch),
        .isImmediate     (isImmediate),
        .isUnconditional (isUnconditional),
        .needsWindow     (needsWindow),
        .destination     (speculativeDestination)
    );

    predictorTables tables_i (
        .clk             (clk),
        .rstN            (rstN),
        .clkEn           (clkEn),
        .fetchAddress    (fetchAddress),
        .lookupHash      (lookupHash),
        .tableValid      (tableValid),
        .tablePrediction (tablePrediction),
        .globalPrediction(globalPrediction),
        .trainEnable     (trainEnable),
        .trainTable      (trainTable),
        .trainHash       (trainHash),
        .trainTaken      (trainTaken)
    );

    speculationControl control_i (
        .clk             (clk),
        .rstN            (rstN),
        .clkEn           (clkEn),
        .isBranch        (isBranch),
        .isImmediate     (isImmediate),
        .isUnconditional (isUnconditional),
        .needsWindow     (needsWindow),
        .lookupHash      (lookupHash),
        .tableValid      (tableValid),
        .tablePrediction (tablePrediction),
        .globalPrediction(globalPrediction),
        .endSpeculation  (endSpeculation),
        .mispredicted    (mispredicted),
        .speculating     (speculating),
        .beginSpeculation(beginSpeculation),
        .speculationStall(speculationStall),
        .predictingTrue  (predictingTrue),
        .trainEnable     (trainEnable),
        .trainTable      (trainTable),
        .trainTaken      (trainTaken),
        .trainHash       (trainHash)
    );

    // Bit 12 of a branch, low for anything else
    assign relativeSpeculation = isImmediate;

endmodule : branchExaminer

/* dv/branchVectors.svh */
`ifndef BRANCH_VECTORS_SVH
`define BRANCH_VECTORS_SVH

// One row per clock cycle
typedef struct {
    int testId;
    logic [2:0] control;
    addrT address;
    instrT instruction;
    logic [4:0] expectFlags;
    addrT expectDestination;
} vectorRowT;

vectorRowT vectors[$];

function automatic string testName(input int id);
    case (id)
        1: return "non-branch and unconditional";
        2: return "window and stall";
        3: return "training";
        4: return "hash aliasing";
        5: return "clock enable low";
        default: return "random destinations";
    endcase
endfunction

task automatic addRow(input int testId, input logic [2:0] control, input addrT address,
                      input instrT instruction, input logic [4:0] expectFlags,
                      input addrT expectDestination);
    vectorRowT row;
    row.testId = testId;
    row.control = control;
    row.address = address;
    row.instruction = instruction;
    row.expectFlags = expectFlags;
    row.expectDestination = expectDestination;
    vectors.push_back(row);
endtask

// Column order is test, {clkEn, endSpeculation, mispredicted}, fetch address, instruction,
// {speculating, beginSpeculation, relativeSpeculation, predictingTrue, stall}, destination
// Addresses 0300 and 0028 both hash to 28, address 0400 hashes to 10
task automatic loadVectors();
    addRow(1, 3'b100, 16'h0100, 16'h0000, 5'b00000, 16'h0000);
    addRow(1, 3'b100, 16'h0100, 16'hC3FF, 5'b00000, 16'h0000);
    addRow(1, 3'b100, 16'h0200, 16'h9010, 5'b00110, 16'h0210);
    addRow(1, 3'b100, 16'h0200, 16'h93F0, 5'b00110, 16'h01F0);
    // Global counter still strongly not-taken
    addRow(2, 3'b100, 16'h0300, 16'h9408, 5'b01100, 16'h0308);
    addRow(2, 3'b100, 16'h0400, 16'h8300, 5'b10001, 16'h0000);
    addRow(2, 3'b110, 16'h0400, 16'h8300, 5'b10001, 16'h0000);
    addRow(2, 3'b100, 16'h0400, 16'h8300, 5'b01000, 16'h0000);
    addRow(2, 3'b100, 16'h0500, 16'h8000, 5'b10011, 16'h0000);
    addRow(2, 3'b110, 16'h0500, 16'h0000, 5'b10000, 16'h0000);
    // Entry at 0300 goes 1, 0, then mispredicts push it to 1 and 2
    addRow(3, 3'b100, 16'h0300, 16'h9408, 5'b01100, 16'h0308);
    addRow(3, 3'b110, 16'h0300, 16'h0000, 5'b10000, 16'h0000);
    addRow(3, 3'b100, 16'h0300, 16'h9408, 5'b01100, 16'h0308);
    addRow(3, 3'b111, 16'h0300, 16'h0000, 5'b10000, 16'h0000);
    addRow(3, 3'b100, 16'h0300, 16'h9408, 5'b01100, 16'h0308);
    addRow(3, 3'b111, 16'h0300, 16'h0000, 5'b10000, 16'h0000);
    addRow(3, 3'b100, 16'h0400, 16'h8300, 5'b01010, 16'h0000);
    addRow(3, 3'b100, 16'h0300, 16'h9408, 5'b10111, 16'h0308);
    // Global counter falls back to 1
    addRow(3, 3'b111, 16'h0400, 16'h0000, 5'b10000, 16'h0000);
    addRow(4, 3'b100, 16'h0400, 16'h8300, 5'b01000, 16'h0000);
    addRow(4, 3'b100, 16'h0028, 16'h9408, 5'b10111, 16'h0030);
    addRow(4, 3'b100, 16'h0400, 16'h9408, 5'b10101, 16'h0408);
    addRow(4, 3'b100, 16'h0300, 16'h8300, 5'b10001, 16'h0000);
    // Frozen end pulse with mispredict
    addRow(5, 3'b011, 16'h0400, 16'h0000, 5'b10000, 16'h0000);
    addRow(5, 3'b000, 16'h0028, 16'h9408, 5'b10111, 16'h0030);
    addRow(5, 3'b000, 16'h0400, 16'h9408, 5'b10101, 16'h0408);
    addRow(5, 3'b110, 16'h0400, 16'h0000, 5'b10000, 16'h0000);
    addRow(5, 3'b000, 16'h0300, 16'h9408, 5'b01110, 16'h0308);
    addRow(5, 3'b000, 16'h0300, 16'h9408, 5'b01110, 16'h0308);
    addRow(5, 3'b100, 16'h0400, 16'h9408, 5'b01100, 16'h0408);
    addRow(5, 3'b110, 16'h0400, 16'h0000, 5'b10000, 16'h0000);
    addRow(5, 3'b100, 16'h0400, 16'h0000, 5'b00000, 16'h0000);
endtask

`endif

/* dv/branchExaminerTb.sv */
`timescale 1ns/100ps

module branchExaminerTb
    import branchPkg::*;
();

    localparam int clockPeriod = 10;
    localparam int resetCycles = 8;
    localparam int randomIterations = 64;
    localparam int driveDelay = 1;
    localparam int sampleDelay = 8;
    localparam int testCount = 6;

    logic clk;
    logic rstN;
    logic clkEn;
    addrT fetchAddress;
    instrT fetchInstruction;
    logic endSpeculation;
    logic mispredicted;

    logic speculating;
    logic beginSpeculation;
    logic relativeSpeculation;
    logic predictingTrue;
    addrT speculativeDestination;
    logic speculationStall;

    int checkCount;
    int errorCount;
    logic vectorsLoaded;

    `include "branchVectors.svh"

    branchExaminer dut_i (
        .clk                   (clk),
        .rstN                  (rstN),
        .clkEn                 (clkEn),
        .fetchAddress          (fetchAddress),
        .fetchInstruction      (fetchInstruction),
        .endSpeculation        (endSpeculation),
        .mispredicted          (mispredicted),
        .speculating           (speculating),
        .beginSpeculation      (beginSpeculation),
        .relativeSpeculation   (relativeSpeculation),
        .predictingTrue        (predictingTrue),
        .speculativeDestination(speculativeDestination),
        .speculationStall      (speculationStall)
    );

    initial begin
        clk = 1'b0;
    end

    always #(clockPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic applyRow(input vectorRowT row);
        @(posedge clk);
        #driveDelay;
        clkEn = row.control[2];
        endSpeculation = row.control[1];
        mispredicted = row.control[0];
        fetchAddress = row.address;
        fetchInstruction = row.instruction;
        #sampleDelay;
        checkValue("speculating", 16'(speculating), 16'(row.expectFlags[4]));
        checkValue("beginSpeculation", 16'(beginSpeculation), 16'(row.expectFlags[3]));
        checkValue("relativeSpeculation", 16'(relativeSpeculation), 16'(row.expectFlags[2]));
        checkValue("predictingTrue", 16'(predictingTrue), 16'(row.expectFlags[1]));
        checkValue("speculationStall", 16'(speculationStall), 16'(row.expectFlags[0]));
        checkValue("speculativeDestination", speculativeDestination, row.expectDestination);
    endtask

    // Even draws use immediate form, odd draws register form
    task automatic runDestinationSweep();
        logic [31:0] lcgState;
        logic [15:0] bits;
        logic [9:0] offset;
        addrT expected;
        logic expectRelative;
        int i;
        lcgState = 32'h6ad2;
        for (i = 0; i < randomIterations; i++) begin
            @(posedge clk);
            #driveDelay;
            lcgState = nextRandom(lcgState);
            fetchAddress = lcgState[31:16];
            lcgState = nextRandom(lcgState);
            bits = lcgState[31:16];
            offset = bits[9:0];
            clkEn = 1'b1;
            endSpeculation = 1'b0;
            mispredicted = 1'b0;
            if ((i % 2) == 0) begin
                fetchInstruction = {2'b10, bits[13], 1'b1, bits[11:0]};
                // Signed word offset added to the fetch address
                expected = fetchAddress + 16'($signed(offset));
                expectRelative = 1'b1;
            end else begin
                fetchInstruction = {2'b10, bits[13], 1'b0, bits[11:0]};
                expected = '0;
                expectRelative = 1'b0;
            end
            #sampleDelay;
            checkValue("speculativeDestination", speculativeDestination, expected);
            checkValue("relativeSpeculation", 16'(relativeSpeculation), 16'(expectRelative));
        end
    endtask

    task automatic reportTest(input int id, input int errorsAtStart);
        $display("Test %0d %s: %0d mismatches", id, testName(id), errorCount - errorsAtStart);
    endtask

    initial begin
        int errorsAtStart;
        int rowIndex;
        vectorRowT row;
        rstN = 1'b0;
        clkEn = 1'b0;
        fetchAddress = '0;
        fetchInstruction = '0;
        endSpeculation = 1'b0;
        mispredicted = 1'b0;
        checkCount = 0;
        errorCount = 0;
        vectorsLoaded = 1'b0;
        loadVectors();
        vectorsLoaded = 1'b1;

        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;
        clkEn = 1'b1;

        errorsAtStart = 0;
        for (rowIndex = 0; rowIndex < vectors.size(); rowIndex++) begin
            row = vectors[rowIndex];
            applyRow(row);
            // Close a test after its last row
            if (rowIndex == vectors.size() - 1 ||
                vectors[rowIndex + 1].testId != row.testId) begin
                reportTest(row.testId, errorsAtStart);
                errorsAtStart = errorCount;
            end
        end

        errorsAtStart = errorCount;
        runDestinationSweep();
        reportTest(testCount, errorsAtStart);

        $display("Summary: %0d tests, %0d checks, %0d failures",
                 testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from table rows, sweep length and reset
    initial begin
        int timeoutCycles;
        wait (vectorsLoaded === 1'b1);
        timeoutCycles = vectors.size() + randomIterations + resetCycles + 50;
        #(timeoutCycles * clockPeriod);
        $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
        $display("tests failed");
        $finish;
    end

endmodule : branchExaminerTb

/* vlog.f */
+incdir+dv
hw/branchPkg.sv
hw/branchDecode.sv
hw/predictorTables.sv
hw/speculationControl.sv
hw/branchExaminer.sv
dv/branchExaminerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the branch examiner testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module branchExaminerTb \
    -o branchExaminerSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/branchExaminerSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

# The log decides the result
if grep -q "^all tests passed$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
